/* hw/bus_pkg.sv */
`default_nettype none

package bus_pkg;

   typedef logic [15:0] bus_addr_t;
   typedef logic [7:0]  bus_data_t;

   typedef enum logic [2:0] {
      REGION_RAM,
      REGION_VIDEO,
      REGION_IO,
      REGION_ROM,
      REGION_NONE
   } region_t;

   localparam int RAM_DEPTH  = 4096;
   localparam int ROM_DEPTH  = 8192;
   localparam int RAM_ADDR_W = $clog2(RAM_DEPTH);
   localparam int ROM_ADDR_W = $clog2(ROM_DEPTH);

   localparam string ROM_INIT_FILE = "hw/rom_init.hex";

   localparam bus_addr_t VIDEO_BASE = 16'h9000; // 128 bytes
   localparam bus_addr_t IO_BASE    = 16'h9200; // 256 bytes
   localparam bus_addr_t ROM_BASE   = 16'hc000; // 8k image seen twice

   localparam bus_data_t UNMAPPED_DATA = 8'hff;

   localparam logic [6:0] VIDEO_BASE_LO_REG = 7'd0;
   localparam logic [6:0] VIDEO_BASE_HI_REG = 7'd1;
   localparam logic [6:0] VIDEO_MODE_REG    = 7'd2;

   localparam logic [7:0] IO_BUTTONS_REG = 8'd0;
   localparam logic [7:0] IO_SCRATCH_REG = 8'd1;

endpackage

`default_nettype wire

/* hw/video_pkg.sv */
`default_nettype none

package video_pkg;

   typedef enum logic [1:0] {
      MODE_640X480   = 2'd1,
      MODE_800X600   = 2'd2,
      MODE_1920X1080 = 2'd3
   } video_mode_t;

   typedef logic [7:0] line_len_t;
   typedef logic [7:0] line_num_t;

   // horizontal pixels / 32
   localparam line_len_t LINE_BYTES_640  = 8'd20;
   localparam line_len_t LINE_BYTES_800  = 8'd25;
   localparam line_len_t LINE_BYTES_1920 = 8'd60;

   localparam int LINE_FIFO_DEPTH = 4;
   localparam int LINE_FIFO_PTR_W = $clog2(LINE_FIFO_DEPTH);
   localparam int LINE_FIFO_CNT_W = $clog2(LINE_FIFO_DEPTH + 1);

   function automatic line_len_t line_bytes(video_mode_t m);
      case (m)
         MODE_640X480: return LINE_BYTES_640;
         MODE_800X600: return LINE_BYTES_800;
         default:      return LINE_BYTES_1920;
      endcase
   endfunction

endpackage

`default_nettype wire

/* hw/mem_bus_if.sv */
`default_nettype none

// one request channel, byte wide, reads answered by rd_valid
interface mem_bus_if;
   import bus_pkg::*;

   logic      req_valid;
   logic      req_ready;
   bus_addr_t addr;
   logic      wr_en;
   bus_data_t wr_data;
   logic      rd_valid;
   bus_data_t rd_data;

   modport master (
      output req_valid, addr, wr_en, wr_data,
      input  req_ready, rd_valid, rd_data
   );

   modport slave (
      input  req_valid, addr, wr_en, wr_data,
      output req_ready, rd_valid, rd_data
   );

endinterface

`default_nettype wire

/* hw/mem_arbiter.sv */
`default_nettype none

module mem_arbiter (
   input  logic       sys_clk,
   input  logic       reset_n,
   mem_bus_if.slave   cpu_bus,
   mem_bus_if.slave   fetch_bus,
   mem_bus_if.master  mem_bus
);

   logic grant_cpu;
   logic grant_fetch;
   logic fetch_first;    // round robin pointer
   logic accepted;
   logic rd_pending;
   logic rd_owner_fetch;

   assign grant_cpu   = cpu_bus.req_valid && (!fetch_bus.req_valid || !fetch_first);
   assign grant_fetch = fetch_bus.req_valid && (!cpu_bus.req_valid || fetch_first);

   // request path is purely combinational
   assign mem_bus.req_valid = grant_cpu || grant_fetch;
   assign mem_bus.addr      = grant_fetch ? fetch_bus.addr    : cpu_bus.addr;
   assign mem_bus.wr_en     = grant_fetch ? fetch_bus.wr_en   : cpu_bus.wr_en;
   assign mem_bus.wr_data   = grant_fetch ? fetch_bus.wr_data : cpu_bus.wr_data;

   assign cpu_bus.req_ready   = grant_cpu && mem_bus.req_ready;
   assign fetch_bus.req_ready = grant_fetch && mem_bus.req_ready;

   assign accepted = mem_bus.req_valid && mem_bus.req_ready;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         fetch_first    <= 1'b0;
         rd_pending     <= 1'b0;
         rd_owner_fetch <= 1'b0;
      end else begin
         if (accepted)
            fetch_first <= grant_cpu; // loser of this round goes first next
         rd_pending     <= accepted && !mem_bus.wr_en;
         rd_owner_fetch <= grant_fetch;
      end
   end

   // memory answers one cycle after acceptance, so one owner flop is enough
   assign cpu_bus.rd_valid   = mem_bus.rd_valid && rd_pending && !rd_owner_fetch;
   assign fetch_bus.rd_valid = mem_bus.rd_valid && rd_pending && rd_owner_fetch;
   assign cpu_bus.rd_data    = mem_bus.rd_data;
   assign fetch_bus.rd_data  = mem_bus.rd_data;

   a_single_grant: assert property (
      @(posedge sys_clk) disable iff (!reset_n)
      !(cpu_bus.req_ready && fetch_bus.req_ready)
   );

   a_return_owned: assert property (
      @(posedge sys_clk) disable iff (!reset_n)
      mem_bus.rd_valid |-> rd_pending
   );

endmodule

`default_nettype wire

/* hw/sys_memory.sv */
`default_nettype none

module sys_memory (
   input  logic                   sys_clk,
   input  logic                   reset_n,
   mem_bus_if.slave               bus,
   input  logic [4:0]             buttons,
   input  video_pkg::video_mode_t mode,
   output bus_pkg::bus_addr_t     display_base
);
   import bus_pkg::*;

   bus_data_t ram_mem [RAM_DEPTH];
   bus_data_t rom_mem [ROM_DEPTH];

   bus_data_t base_lo;
   bus_data_t base_hi;
   bus_data_t scratch;
   bus_data_t ram_q;
   bus_data_t rom_q;
   bus_data_t reg_q;
   bus_data_t reg_next;
   region_t   region;
   region_t   region_q;
   logic      accept;
   logic      wr_acc;

   function automatic region_t decode(bus_addr_t a);
      if (a < bus_addr_t'(RAM_DEPTH))
         return REGION_RAM;
      else if (a[15:7] == VIDEO_BASE[15:7])
         return REGION_VIDEO;
      else if (a[15:8] == IO_BASE[15:8])
         return REGION_IO;
      else if (a >= ROM_BASE)
         return REGION_ROM;
      else
         return REGION_NONE;
   endfunction

   // unlisted rom bytes stay zero
   initial begin
      for (int i = 0; i < ROM_DEPTH; i++)
         rom_mem[i] = '0;
      $readmemh(ROM_INIT_FILE, rom_mem);
   end

   assign bus.req_ready = 1'b1;
   assign accept = bus.req_valid && bus.req_ready;
   assign wr_acc = accept && bus.wr_en;
   assign region = decode(bus.addr);
   assign display_base = {base_hi, base_lo};

   always_comb begin
      reg_next = UNMAPPED_DATA;
      if (region == REGION_VIDEO) begin
         case (bus.addr[6:0])
            VIDEO_BASE_LO_REG: reg_next = base_lo;
            VIDEO_BASE_HI_REG: reg_next = base_hi;
            VIDEO_MODE_REG:    reg_next = {6'b0, mode};
            default:           reg_next = '0;
         endcase
      end else if (region == REGION_IO) begin
         case (bus.addr[7:0])
            IO_BUTTONS_REG: reg_next = {3'b0, buttons};
            IO_SCRATCH_REG: reg_next = scratch;
            default:        reg_next = '0;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (wr_acc && region == REGION_RAM)
         ram_mem[bus.addr[RAM_ADDR_W-1:0]] <= bus.wr_data;
      if (accept) begin
         ram_q    <= ram_mem[bus.addr[RAM_ADDR_W-1:0]];
         rom_q    <= rom_mem[bus.addr[ROM_ADDR_W-1:0]]; // mirrors at 0xe000
         reg_q    <= reg_next;
         region_q <= region;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         bus.rd_valid <= 1'b0;
         base_lo      <= '0;
         base_hi      <= '0;
         scratch      <= '0;
      end else begin
         bus.rd_valid <= accept && !bus.wr_en;
         if (wr_acc && region == REGION_VIDEO && bus.addr[6:0] == VIDEO_BASE_LO_REG)
            base_lo <= bus.wr_data;
         if (wr_acc && region == REGION_VIDEO && bus.addr[6:0] == VIDEO_BASE_HI_REG)
            base_hi <= bus.wr_data;
         if (wr_acc && region == REGION_IO && bus.addr[7:0] == IO_SCRATCH_REG)
            scratch <= bus.wr_data;
      end
   end

   always_comb begin
      case (region_q)
         REGION_RAM: bus.rd_data = ram_q;
         REGION_ROM: bus.rd_data = rom_q;
         default:    bus.rd_data = reg_q;
      endcase
   end

   a_rd_after_read: assert property (
      @(posedge sys_clk) disable iff (!reset_n)
      bus.rd_valid |-> $past(accept && !bus.wr_en)
   );

endmodule

`default_nettype wire

/* hw/line_fetcher.sv */
`default_nettype none

module line_fetcher (
   input  logic                   sys_clk,
   input  logic                   reset_n,
   input  logic                   line_start,
   input  video_pkg::line_num_t   line_num,
   input  video_pkg::video_mode_t mode,
   input  bus_pkg::bus_addr_t     display_base,
   mem_bus_if.master              bus,
   output logic                   pix_valid,
   input  logic                   pix_ready,
   output bus_pkg::bus_data_t     pix_data,
   output logic                   line_busy
);
   import bus_pkg::*;
   import video_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FETCH,
      ST_DRAIN
   } state_t;

   state_t                     state;
   bus_addr_t                  rd_addr;
   bus_addr_t                  start_addr;
   line_len_t                  start_len;
   line_len_t                  req_left;
   logic [LINE_FIFO_CNT_W-1:0] fifo_count;
   logic [LINE_FIFO_CNT_W-1:0] fifo_count_nx;
   logic [LINE_FIFO_CNT_W-1:0] inflight;
   logic [LINE_FIFO_CNT_W-1:0] inflight_nx;
   logic [LINE_FIFO_CNT_W:0]   credit_used;
   logic [LINE_FIFO_PTR_W-1:0] wr_ptr;
   logic [LINE_FIFO_PTR_W-1:0] rd_ptr;
   bus_data_t                  fifo_mem [LINE_FIFO_DEPTH];
   logic                       start;
   logic                       issue;
   logic                       push;
   logic                       pop;

   assign start      = line_start && state == ST_IDLE;
   assign start_len  = line_bytes(mode);
   assign start_addr = display_base + bus_addr_t'(line_num) * bus_addr_t'(start_len);

   // fifo slots plus reads on the way must not exceed the fifo
   assign credit_used = {1'b0, fifo_count} + {1'b0, inflight};

   assign bus.req_valid = state == ST_FETCH && credit_used < LINE_FIFO_DEPTH;
   assign bus.addr      = rd_addr;
   assign bus.wr_en     = 1'b0;
   assign bus.wr_data   = '0;

   assign issue = bus.req_valid && bus.req_ready;
   assign push  = bus.rd_valid;
   assign pop   = pix_valid && pix_ready;

   assign fifo_count_nx = fifo_count + LINE_FIFO_CNT_W'(push) - LINE_FIFO_CNT_W'(pop);
   assign inflight_nx   = inflight + LINE_FIFO_CNT_W'(issue) - LINE_FIFO_CNT_W'(push);

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         state      <= ST_IDLE;
         req_left   <= '0;
         fifo_count <= '0;
         inflight   <= '0;
         wr_ptr     <= '0;
         rd_ptr     <= '0;
      end else begin
         fifo_count <= fifo_count_nx;
         inflight   <= inflight_nx;
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case (state)
            ST_IDLE: if (start) begin
               req_left <= start_len;
               state    <= ST_FETCH;
            end
            ST_FETCH: if (issue) begin
               req_left <= req_left - 1'b1;
               if (req_left == 8'd1)
                  state <= ST_DRAIN; // last read issued
            end
            ST_DRAIN: if (fifo_count_nx == '0 && inflight_nx == '0)
               state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (start)
         rd_addr <= start_addr;
      else if (issue)
         rd_addr <= rd_addr + 1'b1;
      if (push)
         fifo_mem[wr_ptr] <= bus.rd_data;
   end

   assign pix_valid = fifo_count != '0;
   assign pix_data  = fifo_mem[rd_ptr];
   assign line_busy = state != ST_IDLE;

   a_fifo_no_overflow: assert property (
      @(posedge sys_clk) disable iff (!reset_n)
      push |-> (fifo_count < LINE_FIFO_DEPTH || pop)
   );

endmodule

`default_nettype wire

/* hw/mode_control.sv */
`default_nettype none

module mode_control (
   input  logic                   sys_clk,
   input  logic                   reset_n,
   input  logic                   key_mode,
   output video_pkg::video_mode_t mode
);
   import video_pkg::*;

   logic key_meta;
   logic key_sync;
   logic key_prev;
   logic press;

   // key idles high, press pulls it low
   assign press = key_prev && !key_sync;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         key_meta <= 1'b1;
         key_sync <= 1'b1;
         key_prev <= 1'b1;
      end else begin
         key_meta <= key_mode;
         key_sync <= key_meta;
         key_prev <= key_sync;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         mode <= MODE_1920X1080;
      end else if (press) begin
         case (mode)
            MODE_640X480:   mode <= MODE_800X600;
            MODE_800X600:   mode <= MODE_1920X1080;
            MODE_1920X1080: mode <= MODE_640X480;
            default:        mode <= MODE_1920X1080;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/video_system.sv */
`default_nettype none

module video_system (
   input  logic                 sys_clk,
   input  logic                 reset_n,
   input  logic                 key_mode,
   input  logic [4:0]           buttons,
   input  logic                 cpu_valid,
   output logic                 cpu_ready,
   input  bus_pkg::bus_addr_t   cpu_addr,
   input  logic                 cpu_wr_en,
   input  bus_pkg::bus_data_t   cpu_wr_data,
   output logic                 cpu_rd_valid,
   output bus_pkg::bus_data_t   cpu_rd_data,
   input  logic                 line_start,
   input  video_pkg::line_num_t line_num,
   output logic                 pix_valid,
   input  logic                 pix_ready,
   output bus_pkg::bus_data_t   pix_data,
   output logic                 line_busy
);
   import bus_pkg::*;
   import video_pkg::*;

   video_mode_t mode;
   bus_addr_t   display_base;

   mem_bus_if cpu_bus ();
   mem_bus_if fetch_bus ();
   mem_bus_if mem_bus ();

   // processor port onto its bus channel
   assign cpu_bus.req_valid = cpu_valid;
   assign cpu_bus.addr      = cpu_addr;
   assign cpu_bus.wr_en     = cpu_wr_en;
   assign cpu_bus.wr_data   = cpu_wr_data;
   assign cpu_ready         = cpu_bus.req_ready;
   assign cpu_rd_valid      = cpu_bus.rd_valid;
   assign cpu_rd_data       = cpu_bus.rd_data;

   mode_control u_mode (
      .sys_clk  (sys_clk),
      .reset_n  (reset_n),
      .key_mode (key_mode),
      .mode     (mode)
   );

   line_fetcher u_fetch (
      .sys_clk      (sys_clk),
      .reset_n      (reset_n),
      .line_start   (line_start),
      .line_num     (line_num),
      .mode         (mode),
      .display_base (display_base),
      .bus          (fetch_bus.master),
      .pix_valid    (pix_valid),
      .pix_ready    (pix_ready),
      .pix_data     (pix_data),
      .line_busy    (line_busy)
   );

   mem_arbiter u_arb (
      .sys_clk   (sys_clk),
      .reset_n   (reset_n),
      .cpu_bus   (cpu_bus.slave),
      .fetch_bus (fetch_bus.slave),
      .mem_bus   (mem_bus.master)
   );

   sys_memory u_mem (
      .sys_clk      (sys_clk),
      .reset_n      (reset_n),
      .bus          (mem_bus.slave),
      .buttons      (buttons),
      .mode         (mode),
      .display_base (display_base)
   );

endmodule

`default_nettype wire

/* dv/tb_video_system.sv */
`default_nettype none

module tb_video_system;
   timeunit 1ns;
   timeprecision 100ps;
   import bus_pkg::*;
   import video_pkg::*;

   localparam int TIMEOUT_CYCLES = 2000;

   typedef struct packed {
      logic      is_mode;
      bus_data_t data;
   } cpu_exp_t;

   logic        sys_clk;
   logic        reset_n;
   logic        key_mode;
   logic [4:0]  buttons;
   logic        cpu_valid;
   logic        cpu_ready;
   bus_addr_t   cpu_addr;
   logic        cpu_wr_en;
   bus_data_t   cpu_wr_data;
   logic        cpu_rd_valid;
   bus_data_t   cpu_rd_data;
   logic        line_start;
   line_num_t   line_num;
   logic        pix_valid;
   logic        pix_ready;
   bus_data_t   pix_data;
   logic        line_busy;

   logic [15:0] lfsr;
   logic        line_done;
   bus_data_t   model_ram [RAM_DEPTH];
   bus_data_t   model_rom [ROM_DEPTH];
   bus_data_t   model_base_lo;
   bus_data_t   model_base_hi;
   bus_data_t   model_scratch;
   video_mode_t model_mode;
   cpu_exp_t    exp_cpu [$];
   bus_data_t   exp_pix [$];
   cpu_exp_t    exp_head;
   bus_addr_t   addr_log [$];

   video_system uut (.*);

   initial begin
      sys_clk = 1'b0;
      forever #2 sys_clk = ~sys_clk;
   end

   // fibonacci lfsr, one step per bit
   function automatic logic [15:0] rand_bits(int n);
      logic [15:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];
         lfsr = {lfsr[14:0], fb};
         v    = {v[14:0], fb};
      end
      return v;
   endfunction

   function automatic bus_addr_t video_reg(logic [6:0] off);
      return 16'h9000 | bus_addr_t'(off);
   endfunction

   function automatic bus_addr_t io_reg(logic [7:0] off);
      return 16'h9200 | bus_addr_t'(off);
   endfunction

   function automatic line_len_t line_len_for(video_mode_t m);
      case (m)
         MODE_640X480: return LINE_BYTES_640;
         MODE_800X600: return LINE_BYTES_800;
         default:      return LINE_BYTES_1920;
      endcase
   endfunction

   function automatic video_mode_t next_mode(video_mode_t m);
      case (m)
         MODE_640X480: return MODE_800X600;
         MODE_800X600: return MODE_1920X1080;
         default:      return MODE_640X480;
      endcase
   endfunction

   // expected byte for a read at a, from the model image
   function automatic bus_data_t expected_read(bus_addr_t a);
      if (a < 16'h1000)
         return model_ram[a[11:0]];
      if (a[15:7] == 9'h120) begin
         case (a[6:0])
            VIDEO_BASE_LO_REG: return model_base_lo;
            VIDEO_BASE_HI_REG: return model_base_hi;
            VIDEO_MODE_REG:    return {6'b0, model_mode};
            default:           return 8'h00;
         endcase
      end
      if (a[15:8] == 8'h92) begin
         case (a[7:0])
            IO_BUTTONS_REG: return {3'b0, buttons};
            IO_SCRATCH_REG: return model_scratch;
            default:        return 8'h00;
         endcase
      end
      if (a >= 16'hc000)
         return model_rom[a[12:0]]; // 8k mirror
      return UNMAPPED_DATA;
   endfunction

   function automatic void model_write(bus_addr_t a, bus_data_t d);
      if (a < 16'h1000)
         model_ram[a[11:0]] = d;
      else if (a == video_reg(VIDEO_BASE_LO_REG))
         model_base_lo = d;
      else if (a == video_reg(VIDEO_BASE_HI_REG))
         model_base_hi = d;
      else if (a == io_reg(IO_SCRATCH_REG))
         model_scratch = d;
   endfunction

   task automatic check_data(string name, bus_data_t got, bus_data_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
         $display("Testbench failed");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_mode(string name, video_mode_t got, video_mode_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
         $display("Testbench failed");
         $fatal(1, "mode mismatch");
      end
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
         $display("Testbench failed");
         $fatal(1, "flag mismatch");
      end
   endtask

   task automatic timeout_abort(string what);
      $display("timeout: %s", what);
      $display("Testbench failed");
      $fatal(1, "run stopped on timeout");
   endtask

   task automatic cpu_access(bus_addr_t a, logic we, bus_data_t d);
      int waited;
      waited = 0;
      @(posedge sys_clk);
      cpu_valid   <= 1'b1;
      cpu_addr    <= a;
      cpu_wr_en   <= we;
      cpu_wr_data <= d;
      do begin
         @(negedge sys_clk);
         waited++;
         if (waited > TIMEOUT_CYCLES)
            timeout_abort("processor request never accepted");
      end while (!cpu_ready);
      // taken on the coming edge
      if (we)
         model_write(a, d);
      else
         exp_cpu.push_back(cpu_exp_t'{is_mode: a == video_reg(VIDEO_MODE_REG),
                                      data: expected_read(a)});
      @(posedge sys_clk);
      cpu_valid <= 1'b0;
   endtask

   task automatic wait_cpu_idle();
      int waited;
      waited = 0;
      while (exp_cpu.size() != 0) begin
         @(negedge sys_clk);
         waited++;
         if (waited > TIMEOUT_CYCLES)
            timeout_abort("processor reads never returned");
      end
   endtask

   task automatic wait_line_end();
      int waited;
      waited = 0;
      do begin
         @(negedge sys_clk);
         waited++;
         if (waited > TIMEOUT_CYCLES)
            timeout_abort("line fetch did not finish");
      end while (line_busy || exp_pix.size() != 0);
      line_done = 1'b1;
   endtask

   task automatic press_key();
      @(posedge sys_clk);
      key_mode <= 1'b0;
      repeat (6) @(posedge sys_clk);
      key_mode <= 1'b1;
      repeat (6) @(posedge sys_clk); // mode steps 3 cycles after the fall
      model_mode = next_mode(model_mode);
   endtask

   task automatic run_line();
      line_num_t n;
      line_len_t len;
      bus_addr_t a;
      n   = line_num_t'(rand_bits(4));
      len = line_len_for(model_mode);
      a   = {model_base_hi, model_base_lo} + bus_addr_t'(n) * bus_addr_t'(len);
      for (int i = 0; i < int'(len); i++)
         exp_pix.push_back(expected_read(a + bus_addr_t'(i)));
      line_done = 1'b0;
      @(posedge sys_clk);
      line_start <= 1'b1;
      line_num   <= n;
      @(posedge sys_clk);
      line_start <= 1'b0;
      @(negedge sys_clk);
      check_flag("line_busy", line_busy, 1'b1); // start just taken
      fork
         while (!line_done) begin
            @(posedge sys_clk);
            pix_ready <= (rand_bits(1) != 16'd0);
         end
         repeat (10) cpu_access(bus_addr_t'(rand_bits(11)), 1'b0, '0);
         wait_line_end();
      join
      @(posedge sys_clk);
      pix_ready <= 1'b0;
   endtask

   always @(negedge sys_clk) begin
      if (reset_n && cpu_rd_valid) begin
         if (exp_cpu.size() == 0) begin
            $display("processor read data arrived with no read outstanding");
            $display("Testbench failed");
            $fatal(1, "unexpected read return");
         end else begin
            exp_head = exp_cpu.pop_front();
            if (exp_head.is_mode)
               check_mode("cpu_rd_data[1:0]", video_mode_t'(cpu_rd_data[1:0]),
                          video_mode_t'(exp_head.data[1:0]));
            else
               check_data("cpu_rd_data", cpu_rd_data, exp_head.data);
         end
      end
      if (reset_n && pix_valid && pix_ready) begin
         if (exp_pix.size() == 0) begin
            $display("pixel byte transferred beyond the end of the line");
            $display("Testbench failed");
            $fatal(1, "unexpected pixel byte");
         end else begin
            check_flag("line_busy", line_busy, 1'b1); // busy until last byte leaves
            check_data("pix_data", pix_data, exp_pix.pop_front());
         end
      end
   end

   initial begin
      bus_addr_t a;
      reset_n       = 1'b0;
      key_mode      = 1'b1;
      buttons       = '0;
      cpu_valid     = 1'b0;
      cpu_addr      = '0;
      cpu_wr_en     = 1'b0;
      cpu_wr_data   = '0;
      line_start    = 1'b0;
      line_num      = '0;
      pix_ready     = 1'b0;
      lfsr          = 16'd70;
      line_done     = 1'b0;
      model_base_lo = '0;
      model_base_hi = '0;
      model_scratch = '0;
      model_mode    = MODE_1920X1080;
      for (int i = 0; i < ROM_DEPTH; i++)
         model_rom[i] = '0;
      $readmemh("hw/rom_init.hex", model_rom);
      repeat (4) @(posedge sys_clk);
      reset_n <= 1'b1;

      // outputs straight out of reset
      @(negedge sys_clk);
      check_flag("cpu_ready", cpu_ready, 1'b0);
      check_flag("cpu_rd_valid", cpu_rd_valid, 1'b0);
      check_flag("pix_valid", pix_valid, 1'b0);
      check_flag("line_busy", line_busy, 1'b0);

      cpu_access(video_reg(VIDEO_MODE_REG), 1'b0, '0); // mode out of reset
      cpu_access(video_reg(VIDEO_BASE_LO_REG), 1'b0, '0);
      cpu_access(video_reg(VIDEO_BASE_HI_REG), 1'b0, '0);

      // known contents for the display area
      for (int i = 0; i < 2048; i++)
         cpu_access(bus_addr_t'(i), 1'b1, bus_data_t'(rand_bits(8)));

      repeat (24) begin
         a = bus_addr_t'(rand_bits(12));
         addr_log.push_back(a);
         cpu_access(a, 1'b1, bus_data_t'(rand_bits(8)));
      end
      foreach (addr_log[i])
         cpu_access(addr_log[i], 1'b0, '0);
      repeat (8) begin
         a = 16'h1000 + rand_bits(15);
         cpu_access(a, 1'b1, bus_data_t'(rand_bits(8)));
         cpu_access(a, 1'b0, '0);
      end
      wait_cpu_idle();

      repeat (16) begin
         a = 16'hc000 + rand_bits(8);
         if (rand_bits(1) != 16'd0)
            a = a + 16'h2000;
         cpu_access(a, 1'b0, '0);
      end
      repeat (8) begin
         a = 16'hc000 + rand_bits(14);
         cpu_access(a, 1'b1, bus_data_t'(rand_bits(8)));
         cpu_access(a, 1'b0, '0);
         cpu_access(a ^ 16'h2000, 1'b0, '0);
      end
      wait_cpu_idle();

      repeat (4) begin
         @(posedge sys_clk);
         buttons <= 5'(rand_bits(5));
         cpu_access(io_reg(IO_BUTTONS_REG), 1'b0, '0);
      end
      cpu_access(io_reg(IO_SCRATCH_REG), 1'b1, bus_data_t'(rand_bits(8)));
      cpu_access(io_reg(IO_SCRATCH_REG), 1'b0, '0);
      cpu_access(video_reg(VIDEO_BASE_LO_REG), 1'b1, bus_data_t'(rand_bits(8)));
      cpu_access(video_reg(VIDEO_BASE_HI_REG), 1'b1, bus_data_t'(rand_bits(8)));
      cpu_access(video_reg(VIDEO_BASE_LO_REG), 1'b0, '0);
      cpu_access(video_reg(VIDEO_BASE_HI_REG), 1'b0, '0);
      wait_cpu_idle();

      repeat (4) begin
         press_key();
         cpu_access(video_reg(VIDEO_MODE_REG), 1'b0, '0);
      end
      wait_cpu_idle();

      // base stays below 0x400 so every line sits in the filled area
      cpu_access(video_reg(VIDEO_BASE_LO_REG), 1'b1, bus_data_t'(rand_bits(8)));
      cpu_access(video_reg(VIDEO_BASE_HI_REG), 1'b1, bus_data_t'(rand_bits(2)));
      for (int k = 0; k < 6; k++) begin
         run_line();
         if (k % 2 == 1)
            press_key();
      end
      wait_cpu_idle();

      if (exp_cpu.size() != 0 || exp_pix.size() != 0) begin
         $display("expected results left unchecked at the end of the run");
         $display("Testbench failed");
         $fatal(1, "open expectations at end of run");
      end else begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* hw/rom_init.hex */
// rom image, 16 bytes per line from offset 0x00, each byte is its offset xor a5
a5 a4 a7 a6 a1 a0 a3 a2 ad ac af ae a9 a8 ab aa
b5 b4 b7 b6 b1 b0 b3 b2 bd bc bf be b9 b8 bb ba
85 84 87 86 81 80 83 82 8d 8c 8f 8e 89 88 8b 8a
95 94 97 96 91 90 93 92 9d 9c 9f 9e 99 98 9b 9a
e5 e4 e7 e6 e1 e0 e3 e2 ed ec ef ee e9 e8 eb ea
f5 f4 f7 f6 f1 f0 f3 f2 fd fc ff fe f9 f8 fb fa
c5 c4 c7 c6 c1 c0 c3 c2 cd cc cf ce c9 c8 cb ca
d5 d4 d7 d6 d1 d0 d3 d2 dd dc df de d9 d8 db da
25 24 27 26 21 20 23 22 2d 2c 2f 2e 29 28 2b 2a
35 34 37 36 31 30 33 32 3d 3c 3f 3e 39 38 3b 3a
05 04 07 06 01 00 03 02 0d 0c 0f 0e 09 08 0b 0a
15 14 17 16 11 10 13 12 1d 1c 1f 1e 19 18 1b 1a
65 64 67 66 61 60 63 62 6d 6c 6f 6e 69 68 6b 6a
75 74 77 76 71 70 73 72 7d 7c 7f 7e 79 78 7b 7a
45 44 47 46 41 40 43 42 4d 4c 4f 4e 49 48 4b 4a
55 54 57 56 51 50 53 52 5d 5c 5f 5e 59 58 5b 5a

/* tb.f */
hw/bus_pkg.sv
hw/video_pkg.sv
hw/mem_bus_if.sv
hw/mem_arbiter.sv
hw/sys_memory.sv
hw/line_fetcher.sv
hw/mode_control.sv
hw/video_system.sv
dv/tb_video_system.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/100ps \
   --top-module tb_video_system -f tb.f -o tb_video_system
./obj_dir/tb_video_system
